// File: cm_cfg.svh
`ifndef CM_CFG_SVH
`define CM_CFG_SVH

// Stream table size
// Stream id width must cover every entry
`define CM_NUM_STREAMS 64
`define CM_STREAM_W 6

// DFA state width
// Holds the current match length
`define CM_STATE_W 11

// Category count width
`define CM_COUNT_W 16

// Signature under search
// Must have no self-overlap, since the DFA only falls back to the first character
`define CM_SIG "BitTorrent"
`define CM_SIG_LEN 10

`endif

// File: cm_pkg.sv
`include "cm_cfg.svh"

package cm_pkg;

  // One input byte slot
  // sop and eop come on their own cycles, vld marks a data byte
  typedef struct packed {
    logic                     sop;
    logic                     vld;
    logic                     eop;
    // Sampled together with eop
    logic                     enable;
    logic [`CM_STREAM_W-1:0]  stream_id;
    logic [7:0]               data;
  } beat_t;

  // Beat tagged by the stream classifier
  typedef struct packed {
    beat_t beat;
    // Set only on a sop for a stream not seen since reset
    logic  is_new;
  } class_beat_t;

  // Beat with the restored DFA state
  typedef struct packed {
    beat_t                   beat;
    // Replace the DFA state with state_load
    logic                    load;
    logic [`CM_STATE_W-1:0]  state_load;
  } dfa_beat_t;

  // DFA output for one beat
  typedef struct packed {
    logic                     sop;
    logic                     eop;
    logic                     enable;
    logic [`CM_STREAM_W-1:0]  stream_id;
    // State after this beat, saved at eop
    logic [`CM_STATE_W-1:0]   state;
    logic                     accept;
  } dfa_result_t;

endpackage

// File: cm_stage_reg.sv
`timescale 1ns/1ps

// Single pipeline stage for any packed payload
// Used for the input beat and for the DFA result
module cm_stage_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  T     in,
  output T     out
);

  // Whole payload cleared on reset
  // Keeps a stray sop or eop out of the pipe while coming out of reset
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out <= '0;
    end
    else
    begin
      // Advances every clock, no stall
      out <= in;
    end
  end

endmodule

// File: cm_stream_classifier.sv
`timescale 1ns/1ps
`include "cm_cfg.svh"

// Marks the first packet of each stream since reset
module cm_stream_classifier (
  input  logic                clk,
  input  logic                rst_n,
  input  cm_pkg::beat_t       in,
  output cm_pkg::class_beat_t out
);

  // One bit per stream id, set at its first sop
  logic [`CM_NUM_STREAMS-1:0] seen;

  // Stream has never started a packet
  logic                       first_sop;

  // Only a sop beat can be new
  assign first_sop = in.sop && !seen[in.stream_id];

  // Seen bitmap
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen <= '0;
    end
    else if (in.sop)
    begin
      // Stream is known from here on
      seen[in.stream_id] <= 1'b1;
    end
  end

  // Output stage
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out <= '0;
    end
    else
    begin
      out.beat   <= in;
      // Zero on bytes, eop and idle beats
      out.is_new <= first_sop;
    end
  end

endmodule

// File: cm_state_store.sv
`timescale 1ns/1ps
`include "cm_cfg.svh"

// Per-stream DFA state memory
// Restore on sop, save on an enabled eop
module cm_state_store (
  input  logic                clk,
  input  logic                rst_n,
  input  cm_pkg::class_beat_t in,
  input  cm_pkg::dfa_result_t save,
  output cm_pkg::dfa_beat_t   out
);

  // Saved match length per stream
  logic [`CM_STATE_W-1:0]     state_mem [`CM_NUM_STREAMS];

  // Entry holds a written state
  // An entry never saved reads back as the idle state
  logic [`CM_NUM_STREAMS-1:0] saved;

  // Save strobe from the registered DFA result
  logic                       do_save;

  // Disabled packets keep the previous entry
  assign do_save = save.eop && save.enable;

  // Memory write, no reset on the array
  always_ff @(posedge clk)
  begin
    if (do_save)
    begin
      state_mem[save.stream_id] <= save.state;
    end
  end

  // Written-entry bitmap
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      saved <= '0;
    end
    else if (do_save)
    begin
      saved[save.stream_id] <= 1'b1;
    end
  end

  // Restore on sop
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out <= '0;
    end
    else
    begin
      out.beat <= in.beat;
      out.load <= in.beat.sop;
      // New stream or unsaved entry starts from idle
      if (in.beat.sop && !in.is_new && saved[in.beat.stream_id])
      begin
        out.state_load <= state_mem[in.beat.stream_id];
      end
      else
      begin
        out.state_load <= '0;
      end
    end
  end

endmodule

// File: cm_signature_dfa.sv
`timescale 1ns/1ps
`include "cm_cfg.svh"

// Byte-wide DFA for one fixed signature
// State is the number of signature characters matched so far
module cm_signature_dfa (
  input  logic                clk,
  input  logic                rst_n,
  input  cm_pkg::dfa_beat_t   in,
  output cm_pkg::dfa_result_t out
);

  // Signature characters, first character in the top byte
  localparam logic [8*`CM_SIG_LEN-1:0] sig_bits = `CM_SIG;
  localparam logic [`CM_STATE_W-1:0]   sig_len  = `CM_SIG_LEN;

  // Current match length
  logic [`CM_STATE_W-1:0] cur_state;
  // State this beat starts from, after a possible load
  logic [`CM_STATE_W-1:0] base_state;
  logic [`CM_STATE_W-1:0] next_state;
  // Full signature seen on this beat
  logic                   hit;

  // Signature character at a given match length
  function automatic logic [7:0] sig_char(input logic [`CM_STATE_W-1:0] idx);
    int pos;
    pos = `CM_SIG_LEN - 1 - int'(idx);
    return sig_bits[8*pos +: 8];
  endfunction

  // Next-state logic
  always_comb
  begin
    // Load wins over the held state
    base_state = in.load ? in.state_load : cur_state;
    next_state = base_state;
    hit        = 1'b0;
    if (in.beat.vld)
    begin
      if (base_state < sig_len && in.beat.data == sig_char(base_state))
      begin
        if (base_state == sig_len - 1'b1)
        begin
          // Last character, accept and go idle
          next_state = '0;
          hit        = 1'b1;
        end
        else
        begin
          next_state = base_state + 1'b1;
        end
      end
      else if (in.beat.data == sig_char('0))
      begin
        // Mismatch but a fresh start of the signature
        next_state = `CM_STATE_W'(1);
      end
      else
      begin
        next_state = '0;
      end
    end
  end

  // State and result registers
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cur_state <= '0;
      out       <= '0;
    end
    else
    begin
      cur_state     <= next_state;
      out.sop       <= in.beat.sop;
      out.eop       <= in.beat.eop;
      out.enable    <= in.beat.enable;
      out.stream_id <= in.beat.stream_id;
      // On eop this is the state to save
      out.state     <= next_state;
      out.accept    <= hit;
    end
  end

endmodule

// File: cm_match_accumulator.sv
`timescale 1ns/1ps
`include "cm_cfg.svh"

// Sticky per-packet match flag and category count
module cm_match_accumulator (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cm_pkg::dfa_result_t    in,
  output logic                   fired,
  output logic [`CM_COUNT_W-1:0] count
);

  // Packet matched, an accept on the eop beat included
  logic                   pkt_hit;
  logic [`CM_COUNT_W-1:0] count_inc;

  assign pkt_hit   = fired || in.accept;
  assign count_inc = {{(`CM_COUNT_W-1){1'b0}}, pkt_hit};

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fired <= 1'b0;
      count <= '0;
    end
    else
    begin
      // New packet starts unmatched
      if (in.sop)
      begin
        fired <= 1'b0;
      end
      // Any accept in the packet sticks
      if (in.accept)
      begin
        fired <= 1'b1;
      end
      if (in.eop)
      begin
        if (in.enable)
        begin
          count <= count + count_inc;
        end
        else
        begin
          // Disabled packet drops its match
          fired <= 1'b0;
        end
      end
    end
  end

endmodule

// File: cm_matcher_top.sv
`timescale 1ns/1ps
`include "cm_cfg.svh"

// Per-stream signature matcher
// Six stages, no back-pressure
module cm_matcher_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sop,
  input  logic                    vld,
  input  logic                    eop,
  input  logic                    enable,
  input  logic [`CM_STREAM_W-1:0] stream_id,
  input  logic [7:0]              data,
  output logic                    fired,
  output logic [`CM_COUNT_W-1:0]  count
);

  cm_pkg::beat_t       in_beat;
  cm_pkg::beat_t       reg_beat;
  cm_pkg::class_beat_t class_beat;
  cm_pkg::dfa_beat_t   dfa_beat;
  cm_pkg::dfa_result_t dfa_res;
  // Registered result, also the save port of the store
  cm_pkg::dfa_result_t res_reg;

  // Pack the pins into one beat
  assign in_beat = '{sop: sop, vld: vld, eop: eop, enable: enable,
                     stream_id: stream_id, data: data};

  cm_stage_reg #(.T(cm_pkg::beat_t)) i_in_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (in_beat),
    .out   (reg_beat)
  );

  cm_stream_classifier i_classifier (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (reg_beat),
    .out   (class_beat)
  );

  cm_state_store i_state_store (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (class_beat),
    .save  (res_reg),
    .out   (dfa_beat)
  );

  cm_signature_dfa i_dfa (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (dfa_beat),
    .out   (dfa_res)
  );

  cm_stage_reg #(.T(cm_pkg::dfa_result_t)) i_result_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (dfa_res),
    .out   (res_reg)
  );

  cm_match_accumulator i_accumulator (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (res_reg),
    .fired (fired),
    .count (count)
  );

endmodule

// File: cm_matcher_checker.sv
`timescale 1ns/1ps
`include "cm_cfg.svh"

// Protocol checks on the matcher outputs
module cm_matcher_checker (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   eop,
  input logic                   fired,
  input logic [`CM_COUNT_W-1:0] count
);

  // Count moves only when an eop left the input 6 edges before
  a_count_after_eop : assert property (
    @(posedge clk) disable iff (!rst_n)
    $changed(count) |-> $past(eop, 6)
  )
  else $error("count changed without an eop six cycles earlier");

  // Count only ever grows
  a_count_monotonic : assert property (
    @(posedge clk) disable iff (!rst_n)
    count >= $past(count)
  )
  else $error("count decreased");

  // Nothing in flight right after reset
  a_fired_after_reset : assert property (
    @(posedge clk)
    $rose(rst_n) |-> ##2 (fired == 1'b0)
  )
  else $error("fired set two cycles after reset release");

endmodule

bind cm_matcher_top cm_matcher_checker i_cm_matcher_checker (
  .clk   (clk),
  .rst_n (rst_n),
  .eop   (eop),
  .fired (fired),
  .count (count)
);

// File: cm_matcher_tb.sv
`timescale 1ns/1ps
`include "cm_cfg.svh"

// Testbench for the per-stream signature matcher
module cm_matcher_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DLY    = 2;
  localparam int MAX_LEN      = 32;
  localparam int RAND_MAX_LEN = 24;
  localparam int NUM_PKTS     = 12 + 200;
  // Packet bytes plus sop, eop and idle cycles with twofold margin
  localparam int CYCLE_LIMIT  = NUM_PKTS * (MAX_LEN + 8) * 2;

  logic                    clk;
  logic                    rst_n;
  logic                    sop;
  logic                    vld;
  logic                    eop;
  logic                    enable;
  logic [`CM_STREAM_W-1:0] stream_id;
  logic [7:0]              data;
  logic                    fired;
  logic [`CM_COUNT_W-1:0]  count;

  // Reference model state
  logic [`CM_STATE_W-1:0] ref_state [`CM_NUM_STREAMS];
  logic                   ref_seen [`CM_NUM_STREAMS];
  logic [`CM_COUNT_W-1:0] ref_count;
  string                  sig = `CM_SIG;

  // Bytes of the packet being sent
  logic [7:0]             pkt_data [MAX_LEN];
  int                     pkt_len;

  // Expected results in send order
  logic                   exp_fired_q [$];
  logic [`CM_COUNT_W-1:0] exp_count_q [$];
  int                     n_sent = 0;
  int                     n_checked = 0;
  int                     cycles = 0;

  cm_matcher_top i_cm_matcher_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .sop       (sop),
    .vld       (vld),
    .eop       (eop),
    .enable    (enable),
    .stream_id (stream_id),
    .data      (data),
    .fired     (fired),
    .count     (count)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Expected fired for one packet
  // Also advances the per-stream model
  function automatic logic ref_packet(input logic [`CM_STREAM_W-1:0] sid,
                                      input logic en,
                                      output logic [`CM_COUNT_W-1:0] new_count);
    int   st;
    int   i;
    logic hit;
    // Unseen stream starts idle
    st  = ref_seen[sid] ? int'(ref_state[sid]) : 0;
    hit = 1'b0;
    ref_seen[sid] = 1'b1;
    for (i = 0; i < pkt_len; i++)
    begin
      if (pkt_data[i] == sig[st])
      begin
        st = st + 1;
        if (st == `CM_SIG_LEN)
        begin
          hit = 1'b1;
          st  = 0;
        end
      end
      else if (pkt_data[i] == sig[0])
        st = 1;
      else
        st = 0;
    end
    // Disabled packet neither counts nor saves
    if (en)
    begin
      ref_state[sid] = `CM_STATE_W'(st);
      if (hit)
        ref_count = ref_count + 1'b1;
    end
    new_count = ref_count;
    return en && hit;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // One input beat driven just after the rising edge
  task automatic drive_beat(input logic s, input logic v, input logic e, input logic en,
                            input logic [`CM_STREAM_W-1:0] sid, input logic [7:0] d);
    @(posedge clk);
    #DRIVE_DLY;
    sop       = s;
    vld       = v;
    eop       = e;
    enable    = en;
    stream_id = sid;
    data      = d;
  endtask

  task automatic load_string(input string s);
    int i;
    pkt_len = s.len();
    for (i = 0; i < pkt_len; i++)
      pkt_data[i] = s[i];
  endtask

  // Random bytes biased to signature characters
  // Now and then the whole signature is dropped in
  task automatic fill_random();
    int i;
    int pos;
    pkt_len = 1 + ($urandom % RAND_MAX_LEN);
    for (i = 0; i < pkt_len; i++)
    begin
      if ($urandom % 2)
        pkt_data[i] = sig[$urandom % `CM_SIG_LEN];
      else
        pkt_data[i] = 8'($urandom);
    end
    if (($urandom % 4 == 0) && pkt_len >= `CM_SIG_LEN)
    begin
      pos = $urandom % (pkt_len - `CM_SIG_LEN + 1);
      for (i = 0; i < `CM_SIG_LEN; i++)
        pkt_data[pos + i] = sig[i];
    end
  endtask

  task automatic send_packet(input logic [`CM_STREAM_W-1:0] sid, input logic en);
    logic                   exp_f;
    logic [`CM_COUNT_W-1:0] exp_c;
    int                     i;
    exp_f = ref_packet(sid, en, exp_c);
    drive_beat(1'b1, 1'b0, 1'b0, 1'b0, sid, 8'h00);
    for (i = 0; i < pkt_len; i++)
      drive_beat(1'b0, 1'b1, 1'b0, 1'b0, sid, pkt_data[i]);
    exp_fired_q.push_back(exp_f);
    exp_count_q.push_back(exp_c);
    n_sent++;
    drive_beat(1'b0, 1'b0, 1'b1, en, sid, 8'h00);
    // Gap keeps the restore read behind the save
    repeat (4) drive_beat(1'b0, 1'b0, 1'b0, 1'b0, '0, 8'h00);
  endtask

  // Compare process
  // Result settles 6 edges after the eop is driven
  initial
  begin
    logic                   exp_f;
    logic [`CM_COUNT_W-1:0] exp_c;
    forever
    begin
      @(posedge clk);
      if (rst_n && eop)
      begin
        repeat (5) @(posedge clk);
        #1;
        if (exp_fired_q.size() == 0)
        begin
          $display("ERROR: a packet ended but no expected result was queued");
          $display("Finished with errors");
          $fatal(1, "missing expected result");
        end
        else
        begin
          exp_f = exp_fired_q.pop_front();
          exp_c = exp_count_q.pop_front();
          check_value("fired", 32'(exp_f), 32'(fired));
          check_value("count", 32'(exp_c), 32'(count));
          n_checked++;
        end
      end
    end
  end

  // Run limit
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("ERROR: timeout after %0d cycles, the test did not complete", cycles);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    int                      seed_ret;
    int                      i;
    logic [`CM_STREAM_W-1:0] sid;
    seed_ret  = $urandom(32'h032c9099);
    rst_n     = 1'b0;
    sop       = 1'b0;
    vld       = 1'b0;
    eop       = 1'b0;
    enable    = 1'b0;
    stream_id = '0;
    data      = 8'h00;
    ref_count = '0;
    for (i = 0; i < `CM_NUM_STREAMS; i++)
    begin
      ref_state[i] = '0;
      ref_seen[i]  = 1'b0;
    end
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    // Plain hit
    load_string("BitTorrent");
    send_packet(6'd1, 1'b1);
    // Misses and fallback to the first character
    load_string("no signature here");
    send_packet(6'd2, 1'b1);
    load_string("BitBitTorrent");
    send_packet(6'd3, 1'b1);
    load_string("BiBBitTorrent x");
    send_packet(6'd2, 1'b1);
    // Split across packets with another stream between
    load_string("xxBitTo");
    send_packet(6'd4, 1'b1);
    load_string("Torrent");
    send_packet(6'd5, 1'b1);
    load_string("rrentyy");
    send_packet(6'd4, 1'b1);
    // New stream does not pick up another stream's partial match
    load_string("xBitTorr");
    send_packet(6'd6, 1'b1);
    load_string("ent");
    send_packet(6'd7, 1'b1);
    // Disabled packet neither counts nor overwrites the saved state
    load_string("BitTor");
    send_packet(6'd10, 1'b1);
    load_string("rentBitTorrent");
    send_packet(6'd10, 1'b0);
    load_string("rent");
    send_packet(6'd10, 1'b1);

    // Random packets over 8 streams
    for (i = 0; i < 200; i++)
    begin
      fill_random();
      sid = `CM_STREAM_W'($urandom % 8);
      send_packet(sid, 1'($urandom % 2));
    end

    repeat (3) @(posedge clk);
    if (n_checked == n_sent)
    begin
      $display("Finished with no errors");
      $finish;
    end
    else
    begin
      $display("ERROR: only %0d of %0d packets were checked", n_checked, n_sent);
      $display("Finished with errors");
      $fatal(1, "unchecked packets");
    end
  end

endmodule

// File: sources.f
+incdir+.
cm_pkg.sv
cm_stage_reg.sv
cm_stream_classifier.sv
cm_state_store.sv
cm_signature_dfa.sv
cm_match_accumulator.sv
cm_matcher_top.sv
cm_matcher_checker.sv
cm_matcher_tb.sv

// File: Bender.yml
package:
  name: cm_matcher

export_include_dirs:
  - .

sources:
  - files:
      - cm_pkg.sv
      - cm_stage_reg.sv
      - cm_stream_classifier.sv
      - cm_state_store.sv
      - cm_signature_dfa.sv
      - cm_match_accumulator.sv
      - cm_matcher_top.sv
  - target: test
    files:
      - cm_matcher_checker.sv
      - cm_matcher_tb.sv
